//--- logic/mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// ##################################################
// Descriptor type codes, bits [1:0] of each entry
// ##################################################

`define MMU_L1_PAGETABLE  2'b01
`define MMU_L1_SECTION    2'b10

`define MMU_L2_FAULT      2'b00
`define MMU_L2_LARGE      2'b01
`define MMU_L2_SMALL      2'b10
`define MMU_L2_SMALLEXT   2'b11

// ##################################################
// Virtual address slices on a word address (ptr)
// ##################################################

`define MMU_L1_INDEX      [29:18]  // Virtual 31:20
`define MMU_L2_INDEX      [17:10]  // Virtual 19:12
`define MMU_SECTION_INDEX [17:0]   // Virtual 19:2
`define MMU_LARGE_INDEX   [13:0]   // Virtual 15:2
`define MMU_SMALL_INDEX   [9:0]    // Virtual 11:2

// Fault log counter
`define MMU_FAULT_COUNT_W 8

`endif

//--- logic/core_types_pkg.sv
package core_types_pkg;

	// ##################################################
	// Core side data and address types
	// ##################################################

	typedef logic [31:0] word;

	// Word address, byte lanes come from the enables
	typedef logic [29:0] ptr;

	// One load or store as issued by the core
	typedef struct packed {
		ptr         addr;
		word        data_wr;
		logic [3:0] be;       // Byte enables, bit 0 is the lowest lane
		logic       write;    // 1 for store
	} core_req;

endpackage

//--- logic/mmu_format_pkg.sv
package mmu_format_pkg;

	import core_types_pkg::*;

	// First-level table base, 16 KiB aligned
	typedef logic [17:0] mmu_base;

	// ##################################################
	// Short-descriptor entry layouts
	// ##################################################

	typedef struct packed {
		logic [21:0] base;       // Second-level table, 1 KiB aligned
		logic [7:0]  unused;
		logic [1:0]  desc_type;
	} mmu_l1_pagetable;

	typedef struct packed {
		logic [11:0] base;       // 1 MiB section
		logic [17:0] unused;
		logic [1:0]  desc_type;
	} mmu_l1_section;

	typedef struct packed {
		logic [15:0] base;       // 64 KiB page
		logic [13:0] unused;
		logic [1:0]  desc_type;
	} mmu_l2_large;

	typedef struct packed {
		logic [19:0] base;       // 4 KiB page
		logic [9:0]  unused;
		logic [1:0]  desc_type;
	} mmu_l2_small;

	// Access on the memory bus
	typedef struct packed {
		ptr         addr;
		word        data_wr;
		logic [3:0] be;
		logic       write;
	} bus_req;

	typedef enum logic [1:0] {
		mmu_fault_none,
		mmu_l1_fault,     // Invalid or unsupported first-level entry
		mmu_l2_fault      // Second-level fault entry
	} mmu_fault_kind;

endpackage

//--- logic/core_mmu_pagewalk.sv
`include "mmu_config.svh"

module core_mmu_pagewalk
	import core_types_pkg::*, mmu_format_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    mmu_enable,
	input  mmu_base                 mmu_ttbr,

	input  logic                    core_start,
	input  core_types_pkg::core_req core_req,

	input  logic                    bus_ready,
	input  word                     bus_data_rd,

	output logic                    core_ready,
	output logic                    core_fault,
	output word                     core_data_rd,
	output ptr                      core_fault_addr,
	output mmu_fault_kind           core_fault_kind,

	output logic                    bus_start,
	output mmu_format_pkg::bus_req  bus_req
);

	typedef enum logic [2:0] {
		st_idle,
		st_l1,
		st_l2,
		st_data,
		st_fault
	} walk_state;

	walk_state state;

	// Fetched word seen through each descriptor layout
	mmu_l1_pagetable l1_table;
	mmu_l1_section   l1_section;
	mmu_l2_large     l2_large;
	mmu_l2_small     l2_small;

	assign l1_table   = bus_data_rd;
	assign l1_section = bus_data_rd;
	assign l2_large   = bus_data_rd;
	assign l2_small   = bus_data_rd;

	core_types_pkg::core_req hold;  // Request under translation

	ptr         bus_addr;
	word        bus_data_wr;
	logic [3:0] bus_be;
	logic       bus_write;

	assign bus_req = '{addr: bus_addr, data_wr: bus_data_wr, be: bus_be, write: bus_write};

	// ##################################################
	// Control
	// ##################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			bus_start    <= 1'b0;
			bus_write    <= 1'b0;
			core_ready   <= 1'b0;
			core_fault   <= 1'b0;
			core_data_rd <= '0;
		end else begin
			bus_start  <= 1'b0;
			core_ready <= 1'b0;
			core_fault <= 1'b0;

			unique case (state)
				st_idle:
					if (core_start) begin
						bus_start <= 1'b1;
						if (mmu_enable) begin
							state <= st_l1;
						end else begin
							state     <= st_data;
							bus_write <= core_req.write;  // Untranslated access
						end
					end

				st_l1:
					if (bus_ready) begin
						unique case (l1_table.desc_type)
							`MMU_L1_PAGETABLE: begin
								state     <= st_l2;
								bus_start <= 1'b1;
							end
							`MMU_L1_SECTION: begin
								state     <= st_data;
								bus_start <= 1'b1;
								bus_write <= hold.write;
							end
							default:
								state <= st_fault;  // Fault, tiny page or supersection
						endcase
					end

				st_l2:
					if (bus_ready) begin
						if (l2_small.desc_type == `MMU_L2_FAULT) begin
							state <= st_fault;
						end else begin
							state     <= st_data;
							bus_start <= 1'b1;
							bus_write <= hold.write;
						end
					end

				st_data:
					if (bus_ready) begin
						state        <= st_idle;
						bus_write    <= 1'b0;
						core_ready   <= 1'b1;
						core_data_rd <= bus_data_rd;
					end

				st_fault: begin
					state      <= st_idle;
					bus_write  <= 1'b0;
					core_ready <= 1'b1;
					core_fault <= 1'b1;
				end

				default:
					state <= st_idle;
			endcase
		end
	end

	// ##################################################
	// Addresses and payload
	// ##################################################

	always_ff @(posedge clk) begin
		unique case (state)
			st_idle:
				if (core_start) begin
					hold        <= core_req;
					bus_data_wr <= core_req.data_wr;
					if (mmu_enable) begin
						bus_addr <= {mmu_ttbr, core_req.addr`MMU_L1_INDEX};
						bus_be   <= 4'hf;  // Descriptor fetch
					end else begin
						bus_addr <= core_req.addr;
						bus_be   <= core_req.be;
					end
				end

			st_l1:
				if (bus_ready) begin
					if (l1_table.desc_type == `MMU_L1_PAGETABLE) begin
						bus_addr <= {l1_table.base, hold.addr`MMU_L2_INDEX};
					end else begin
						bus_addr <= {l1_section.base, hold.addr`MMU_SECTION_INDEX};
						bus_be   <= hold.be;
					end
					core_fault_kind <= mmu_l1_fault;
				end

			st_l2:
				if (bus_ready) begin
					if (l2_large.desc_type == `MMU_L2_LARGE)
						bus_addr <= {l2_large.base, hold.addr`MMU_LARGE_INDEX};
					else
						bus_addr <= {l2_small.base, hold.addr`MMU_SMALL_INDEX};  // Small and extended
					bus_be          <= hold.be;
					core_fault_kind <= mmu_l2_fault;
				end

			st_fault:
				core_fault_addr <= hold.addr;

			default: ;
		endcase
	end

endmodule

//--- logic/core_mmu_fault_log.sv
`include "mmu_config.svh"

module core_mmu_fault_log
	import core_types_pkg::*, mmu_format_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          core_fault,
	input  ptr                            core_fault_addr,
	input  mmu_fault_kind                 core_fault_kind,
	input  logic                          fault_ack,

	output logic                          fault_pending,
	output ptr                            fault_addr,
	output mmu_fault_kind                 fault_kind,
	output logic [`MMU_FAULT_COUNT_W-1:0] fault_count
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_pending <= 1'b0;
			fault_kind    <= mmu_fault_none;
			fault_count   <= '0;
		end else if (core_fault) begin
			fault_pending <= 1'b1;  // New fault beats a simultaneous ack
			fault_kind    <= core_fault_kind;
			if (fault_ack)
				fault_count <= `MMU_FAULT_COUNT_W'(1);
			else if (!(&fault_count))
				fault_count <= fault_count + 1'b1;  // Saturates at all ones
		end else if (fault_ack) begin
			fault_pending <= 1'b0;
			fault_count   <= '0;
		end
	end

	// Last faulting virtual address
	always_ff @(posedge clk) begin
		if (core_fault)
			fault_addr <= core_fault_addr;
	end

endmodule

//--- logic/core_mmu.sv
`include "mmu_config.svh"

module core_mmu
	import core_types_pkg::*, mmu_format_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          mmu_enable,
	input  mmu_base                       mmu_ttbr,
	input  logic                          fault_ack,

	input  logic                          core_start,
	input  core_types_pkg::core_req       core_req,
	output logic                          core_ready,
	output logic                          core_fault,
	output word                           core_data_rd,

	output logic                          bus_start,
	output mmu_format_pkg::bus_req        bus_req,
	input  logic                          bus_ready,
	input  word                           bus_data_rd,

	output logic                          fault_pending,
	output ptr                            fault_addr,
	output mmu_fault_kind                 fault_kind,
	output logic [`MMU_FAULT_COUNT_W-1:0] fault_count
);

	ptr            walk_fault_addr;
	mmu_fault_kind walk_fault_kind;

	core_mmu_pagewalk i_pagewalk (
		.clk             (clk),
		.rst_n           (rst_n),
		.mmu_enable      (mmu_enable),
		.mmu_ttbr        (mmu_ttbr),
		.core_start      (core_start),
		.core_req        (core_req),
		.bus_ready       (bus_ready),
		.bus_data_rd     (bus_data_rd),
		.core_ready      (core_ready),
		.core_fault      (core_fault),
		.core_data_rd    (core_data_rd),
		.core_fault_addr (walk_fault_addr),
		.core_fault_kind (walk_fault_kind),
		.bus_start       (bus_start),
		.bus_req         (bus_req)
	);

	core_mmu_fault_log i_fault_log (
		.clk             (clk),
		.rst_n           (rst_n),
		.core_fault      (core_fault),
		.core_fault_addr (walk_fault_addr),
		.core_fault_kind (walk_fault_kind),
		.fault_ack       (fault_ack),
		.fault_pending   (fault_pending),
		.fault_addr      (fault_addr),
		.fault_kind      (fault_kind),
		.fault_count     (fault_count)
	);

endmodule

//--- tb/core_mmu_properties.sv
module core_mmu_properties
	import mmu_format_pkg::*;
(
	input logic                   clk,
	input logic                   rst_n,
	input logic                   core_start,
	input logic                   core_ready,
	input logic                   core_fault,
	input logic                   bus_start,
	input mmu_format_pkg::bus_req bus_req,
	input logic                   bus_ready
);

	logic bus_busy;  // From the cycle after bus_start up to bus_ready
	int   n_failures = 0;  // Failed checks so far

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bus_busy <= 1'b0;
		else if (bus_start)
			bus_busy <= 1'b1;
		else if (bus_ready)
			bus_busy <= 1'b0;
	end

	a_bus_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		bus_start |=> !bus_start)
	else begin
		$error("bus_start held longer than one cycle");
		n_failures++;
	end

	a_core_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		core_start |=> !core_start)
	else begin
		$error("core_start held longer than one cycle");
		n_failures++;
	end

	a_bus_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		bus_busy |-> $stable(bus_req))
	else begin
		$error("bus_req changed before bus_ready");
		n_failures++;
	end

	a_fault_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		core_fault |-> core_ready)
	else begin
		$error("core_fault without core_ready");
		n_failures++;
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		bus_busy |-> !bus_start)
	else begin
		$error("bus_start while an access is outstanding");
		n_failures++;
	end

endmodule

bind core_mmu core_mmu_properties i_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.core_start (core_start),
	.core_ready (core_ready),
	.core_fault (core_fault),
	.bus_start  (bus_start),
	.bus_req    (bus_req),
	.bus_ready  (bus_ready)
);

//--- tb/core_mmu_tb.sv
`include "mmu_config.svh"

module core_mmu_tb
	import core_types_pkg::*, mmu_format_pkg::*;
();

	typedef logic [`MMU_FAULT_COUNT_W-1:0] fault_cnt;

	// One test line of the stimulus file
	typedef struct packed {
		logic          enable;
		mmu_base       ttbr;
		logic [1:0]    op;         // 0 read, 1 write, 2 fault ack
		ptr            vaddr;
		word           data_wr;
		logic [3:0]    be;
		word           exp_rd;
		logic          exp_fault;
		mmu_fault_kind exp_kind;
		fault_cnt      exp_count;  // Log count after the test
	} stim_test;

	localparam int CLK_HALF        = 20;
	localparam int RESET_CYCLES    = 8;
	localparam int CYCLES_PER_TEST = 20;

	logic                    clk;
	logic                    rst_n;
	logic                    mmu_enable;
	mmu_base                 mmu_ttbr;
	logic                    fault_ack;
	logic                    core_start;
	core_types_pkg::core_req core_req;
	logic                    core_ready;
	logic                    core_fault;
	word                     core_data_rd;
	logic                    bus_start;
	mmu_format_pkg::bus_req  bus_req;
	logic                    bus_ready;
	word                     bus_data_rd;
	logic                    fault_pending;
	ptr                      fault_addr;
	mmu_fault_kind           fault_kind;
	fault_cnt                fault_count;

	word      mem [ptr];  // Sparse word memory
	stim_test tests [$];
	int       seed = 32838;
	int       n_errors = 0;
	int       n_pass = 0;
	int       n_fail = 0;
	logic     loaded = 1'b0;

	core_mmu i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ##################################################
	// Compare tasks
	// ##################################################

	task automatic check_word(input string what, input word got, input word exp);
		if (got !== exp) begin
			$display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_ptr(input string what, input ptr got, input ptr exp);
		if (got !== exp) begin
			$display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_count(input string what, input fault_cnt got, input fault_cnt exp);
		if (got !== exp) begin
			$display("** Error @%0t: %s is %0d, expected %0d", $time, what, got, exp);
			n_errors++;
		end
	endtask

	// Kind only matters when a fault is expected
	task automatic check_fault(input string what, input logic got_flag,
			input mmu_fault_kind got_kind, input logic exp_flag, input mmu_fault_kind exp_kind);
		if (got_flag !== exp_flag || (exp_flag && got_kind !== exp_kind)) begin
			$display("** Error @%0t: %s is %b/%0d, expected %b/%0d", $time, what,
				got_flag, got_kind, exp_flag, exp_kind);
			n_errors++;
		end
	endtask

	// ##################################################
	// Stimulus file and memory model
	// ##################################################

	task automatic read_stim(output logic ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [10];
		stim_test    t;
		ok = 1'b1;
		fd = $fopen("tb/core_mmu_stim.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] == "M") begin
					n = $sscanf(line, "M %h %h", f[0], f[1]);
					if (n == 2)
						mem[f[0][29:0]] = f[1];
					else
						ok = 1'b0;
				end else if (line.len() > 0 && line[0] == "T") begin
					n = $sscanf(line, "T %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
						f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
					if (n != 10)
						ok = 1'b0;
					t.enable    = f[0][0];
					t.ttbr      = f[1][17:0];
					t.op        = f[2][1:0];
					t.vaddr     = f[3][29:0];
					t.data_wr   = f[4];
					t.be        = f[5][3:0];
					t.exp_rd    = f[6];
					t.exp_fault = f[7][0];
					t.exp_kind  = mmu_fault_kind'(f[8][1:0]);
					t.exp_count = f[9][`MMU_FAULT_COUNT_W-1:0];
					tests.push_back(t);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin : memory_model
		mmu_format_pkg::bus_req acc;
		int                     delay;
		word                    rd;
		bus_ready   <= 1'b0;
		bus_data_rd <= '0;
		forever begin
			@(posedge clk);
			bus_ready <= 1'b0;
			if (bus_start) begin
				acc   = bus_req;
				delay = 1 + ({$random(seed)} % 4);  // 1 to 4 cycles
				repeat (delay - 1) @(posedge clk);
				rd = mem.exists(acc.addr) ? mem[acc.addr] : '0;
				if (acc.write) begin
					for (int b = 0; b < 4; b++)
						if (acc.be[b])
							rd[8*b +: 8] = acc.data_wr[8*b +: 8];
					mem[acc.addr] = rd;
				end
				bus_ready   <= 1'b1;
				bus_data_rd <= rd;
			end
		end
	end

	// ##################################################
	// Test sequence
	// ##################################################

	task automatic run_access(input stim_test t, input logic rd_known, input word last_rd);
		word  rd;
		logic flt;
		logic seen;
		int   waited;
		@(posedge clk);
		mmu_enable <= t.enable;
		mmu_ttbr   <= t.ttbr;
		core_req   <= '{addr: t.vaddr, data_wr: t.data_wr, be: t.be, write: t.op == 2'd1};
		core_start <= 1'b1;
		@(posedge clk);
		core_start <= 1'b0;
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < CYCLES_PER_TEST) begin
			@(posedge clk);
			waited++;
			if (core_ready) begin
				seen = 1'b1;
				flt  = core_fault;
				rd   = core_data_rd;
			end
		end
		if (!seen) begin
			$display("No core_ready within %0d cycles for address %h", CYCLES_PER_TEST, t.vaddr);
			n_errors++;
		end else begin
			@(posedge clk);  // Fault log settles
			check_fault("core_fault", flt, fault_kind, t.exp_fault, t.exp_kind);
			if (t.exp_fault && rd_known)
				check_word("core_data_rd after fault", rd, last_rd);
			else if (!t.exp_fault && t.op == 2'd0)
				check_word("read data", rd, t.exp_rd);
		end
	endtask

	task automatic pulse_ack();
		@(posedge clk);
		fault_ack <= 1'b1;
		@(posedge clk);
		fault_ack <= 1'b0;
		@(posedge clk);
	endtask

	initial begin : watchdog
		wait (loaded);
		repeat (RESET_CYCLES + tests.size() * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog expired before all %0d tests were done", tests.size());
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main
		int            errors_before;
		logic          ok;
		ptr            last_addr;
		mmu_fault_kind last_kind;
		logic          rd_known;
		word           last_rd;  // Data of the last completed read
		rst_n      <= 1'b0;
		mmu_enable <= 1'b0;
		mmu_ttbr   <= '0;
		fault_ack  <= 1'b0;
		core_start <= 1'b0;
		core_req   <= '0;
		last_addr = '0;
		last_kind = mmu_fault_none;
		rd_known  = 1'b0;
		last_rd   = '0;
		read_stim(ok);
		loaded = ok;
		if (!ok) begin
			$display("Stimulus file missing or malformed, no tests run");
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			rst_n <= 1'b1;
			foreach (tests[i]) begin
				errors_before = n_errors + i_dut.i_properties.n_failures;
				if (tests[i].op == 2'd2)
					pulse_ack();
				else
					run_access(tests[i], rd_known, last_rd);
				if (tests[i].exp_fault) begin
					last_addr = tests[i].vaddr;
					last_kind = tests[i].exp_kind;
				end
				if (tests[i].op == 2'd0 && !tests[i].exp_fault) begin
					rd_known = 1'b1;
					last_rd  = tests[i].exp_rd;
				end else if (tests[i].op == 2'd1 && !tests[i].exp_fault) begin
					rd_known = 1'b0;
				end
				check_count("fault_count", fault_count, tests[i].exp_count);
				check_fault("fault_pending", fault_pending, fault_kind,
					tests[i].exp_count != 0, last_kind);
				if (tests[i].exp_count != 0)
					check_ptr("fault_addr", fault_addr, last_addr);
				if (n_errors + i_dut.i_properties.n_failures == errors_before) begin
					n_pass++;
					$display("Test %0d at %h passed", i, tests[i].vaddr);
				end else begin
					n_fail++;
					$display("Test %0d at %h failed", i, tests[i].vaddr);
				end
			end
		end
		@(posedge clk);
		$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
		if (ok && n_fail == 0 && i_dut.i_properties.n_failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- sources.f
+incdir+logic
logic/core_types_pkg.sv
logic/mmu_format_pkg.sv
logic/core_mmu_pagewalk.sv
logic/core_mmu_fault_log.sv
logic/core_mmu.sv
tb/core_mmu_properties.sv
tb/core_mmu_tb.sv

//--- tb/core_mmu_stim.txt
# M <word addr> <data>  preloads memory, all values hex
# T <en> <ttbr> <op 0 rd 1 wr 2 ack> <vaddr> <wdata> <be> <exp rd> <exp fault> <exp kind> <exp count>
M 00000100 A5A5A5A5
M 00010001 02000002  L1 section, base 020
M 00010002 00300001  L1 page table at 000C0000
M 00010003 00000000  L1 fault
M 00010004 00000003  L1 unsupported code
M 000C0000 01230001  L2 large, base 0123
M 000C0010 00456002  L2 small, base 00456
M 000C0011 00789003  L2 extended small, base 00789
M 000C0012 DEAD0000  L2 fault
M 00800123 CAFE0001
M 0048C045 1A46E001
M 001158AB 5A11000B
M 001E2410 E7700010
# MMU off, partial write merges lanes 2 and 0
T 0 00000 0 00000100 00000000 F A5A5A5A5 0 0 0
T 0 00000 1 00000100 11223344 5 00000000 0 0 0
T 0 00000 0 00000100 00000000 F A522A544 0 0 0
# Section mapping
T 1 00010 0 00040123 00000000 F CAFE0001 0 0 0
T 1 00010 1 00040124 55667788 F 00000000 0 0 0
T 1 00010 1 00040124 AA000000 8 00000000 0 0 0
T 1 00010 0 00040124 00000000 F AA667788 0 0 0
T 0 00000 0 00800124 00000000 F AA667788 0 0 0
# Large, small and extended small pages
T 1 00010 0 00080045 00000000 F 1A46E001 0 0 0
T 1 00010 0 000840AB 00000000 F 5A11000B 0 0 0
T 1 00010 0 00084410 00000000 F E7700010 0 0 0
T 1 00010 1 00084410 0000BEEF 3 00000000 0 0 0
T 1 00010 0 00084410 00000000 F E770BEEF 0 0 0
# Faults, log and acknowledge
T 1 00010 0 000C0007 00000000 F 00000000 1 1 1
T 1 00010 1 00084805 12345678 F 00000000 1 2 2
T 1 00010 0 00100009 00000000 F 00000000 1 1 3
T 1 00010 0 00040123 00000000 F CAFE0001 0 0 3
T 0 00000 2 00000000 00000000 0 00000000 0 0 0
T 1 00010 0 00080045 00000000 F 1A46E001 0 0 0
T 1 00010 0 00084805 00000000 F 00000000 1 2 1
T 0 00000 2 00000000 00000000 0 00000000 0 0 0
